/* flist.f */
logic/fu_gst_pkg.sv
logic/fu_gst_add11.sv
logic/fu_gst_ex1_if.sv
logic/fu_gst_tbl.sv
logic/fu_gst_ex1.sv
logic/fu_gst_ex2.sv
logic/fu_gst.sv
verification/tb_clkgen.sv
verification/tb_fu_gst.sv

/* logic/fu_gst.sv */
/*
 * graphics estimate side pipe top
 * floge and fexpte, two stages, fixed latency of two cycles
 */

`timescale 1ns/1ps

module fu_gst import fu_gst_pkg::*; #(
   parameter int tbl_idx_w = 4   // fraction bits indexing the tables
) (
   input  logic         nclk,
   input  logic         rst,
   input  logic         ex0_valid,
   input  gst_op_t      ex0_op,
   input  logic [31:0]  ex0_opnd,
   output logic         ex2_valid,
   output logic [31:0]  ex2_rslt,
   output logic         ex2_invalid
);

   fu_gst_ex1_if ex1 ();   // stage 1 results

   // decode and lookup
   fu_gst_ex1 #(
      .tbl_idx_w (tbl_idx_w)
   ) i_ex1 (
      .nclk      (nclk),
      .rst       (rst),
      .ex0_valid (ex0_valid),
      .ex0_op    (ex0_op),
      .ex0_opnd  (ex0_opnd),
      .ex1       (ex1.src)
   );

   // add and pack
   fu_gst_ex2 i_ex2 (
      .nclk        (nclk),
      .rst         (rst),
      .ex1         (ex1.dst),
      .ex2_valid   (ex2_valid),
      .ex2_rslt    (ex2_rslt),
      .ex2_invalid (ex2_invalid)
   );

endmodule : fu_gst

/* logic/fu_gst_add11.sv */
/*
 * 11 bit prefix adder for the estimate fraction
 * both addends arrive inverted, sum comes out true
 * bit 0 is the msb, no carry in and no carry out
 */

`timescale 1ns/1ps

module fu_gst_add11 (
   input  logic [0:10] a_b,   // inverted addend
   input  logic [0:10] b_b,   // inverted addend
   output logic [0:10] s0     // true sum mod 2048
);

   logic [0:10] p1;     // half sum
   logic [1:10] g1;     // bit generate
   logic [1:9]  t1;     // bit transmit
   logic [1:10] g2_b;
   logic [1:8]  t2_b;
   logic [1:10] g4;
   logic [1:6]  t4;
   logic [1:10] g8_b;
   logic [1:2]  t8_b;
   logic [1:10] c16;    // carry into bit i-1

   // inputs are inverted so nor gives generate and nand gives transmit
   assign p1 = a_b ^ b_b;
   assign g1 = ~(a_b[1:10] | b_b[1:10]);
   assign t1 = ~(a_b[1:9] & b_b[1:9]);

   // ------------------------------
   // carry tree
   // ------------------------------
   // span 2, low polarity
   for (genvar i = 1; i <= 9; i++) begin : g_l2_g
      assign g2_b[i] = ~(g1[i] | (t1[i] & g1[i+1]));
   end
   assign g2_b[10] = ~g1[10];   // lsb has nothing below
   for (genvar i = 1; i <= 8; i++) begin : g_l2_t
      assign t2_b[i] = ~(t1[i] & t1[i+1]);
   end

   // span 4, high polarity
   for (genvar i = 1; i <= 8; i++) begin : g_l4_g
      assign g4[i] = ~(g2_b[i] & (t2_b[i] | g2_b[i+2]));
   end
   for (genvar i = 9; i <= 10; i++) begin : g_l4_p
      assign g4[i] = ~g2_b[i];
   end
   for (genvar i = 1; i <= 6; i++) begin : g_l4_t
      assign t4[i] = ~(t2_b[i] | t2_b[i+2]);
   end

   // span 8, low polarity
   for (genvar i = 1; i <= 6; i++) begin : g_l8_g
      assign g8_b[i] = ~(g4[i] | (t4[i] & g4[i+4]));
   end
   for (genvar i = 7; i <= 10; i++) begin : g_l8_p
      assign g8_b[i] = ~g4[i];
   end
   for (genvar i = 1; i <= 2; i++) begin : g_l8_t
      assign t8_b[i] = ~(t4[i] & t4[i+4]);
   end

   // span 16 covers the whole word
   for (genvar i = 1; i <= 2; i++) begin : g_l16_g
      assign c16[i] = ~(g8_b[i] & (t8_b[i] | g8_b[i+8]));
   end
   for (genvar i = 3; i <= 10; i++) begin : g_l16_p
      assign c16[i] = ~g8_b[i];
   end

   // ------------------------------
   // sum
   // ------------------------------
   assign s0[0:9] = p1[0:9] ^ c16[1:10];
   assign s0[10]  = p1[10];              // no carry in

endmodule : fu_gst_add11

/* logic/fu_gst_ex1.sv */
/*
 * stage 1 of the estimate pipe
 * operand decode, special case detect, table lookup
 * results registered into the stage 1 bundle
 */

`timescale 1ns/1ps

module fu_gst_ex1 import fu_gst_pkg::*; #(
   parameter int tbl_idx_w = 4
) (
   input  logic         nclk,
   input  logic         rst,
   input  logic         ex0_valid,
   input  gst_op_t      ex0_op,
   input  logic [31:0]  ex0_opnd,
   fu_gst_ex1_if.src    ex1
);

   logic                  sgn;       // float sign
   logic [7:0]            bexp;      // biased exponent
   logic [gst_fix_w-1:0]  fix;       // 8.11 operand of fexpte
   logic [gst_int_w-1:0]  int_d;
   logic [gst_frac_w-1:0] frac_d;
   logic [gst_frac_w-1:0] corr_d;
   logic                  inv_d;

   assign sgn  = ex0_opnd[31];
   assign bexp = ex0_opnd[30:23];
   assign fix  = ex0_opnd[gst_fix_w-1:0];

   // ------------------------------
   // decode
   // ------------------------------
   always_comb begin
      if (ex0_op == op_floge) begin
         int_d  = bexp - gst_int_w'(gst_exp_bias);   // unbiased exponent
         frac_d = ex0_opnd[22 -: gst_frac_w];         // mantissa top bits
         // negative, zero or denormal, inf or nan
         inv_d  = sgn | (bexp == 8'h00) | (bexp == 8'hff);
      end else begin
         int_d  = fix[gst_fix_w-1 -: gst_int_w];
         frac_d = fix[gst_frac_w-1:0];
         // range judged on the whole signed integer part
         inv_d  = ($signed(ex0_opnd[31:gst_frac_w]) < gst_exp_min) |
                  ($signed(ex0_opnd[31:gst_frac_w]) > gst_exp_max);
      end
   end

   // segment correction from top fraction bits
   fu_gst_tbl #(
      .tbl_idx_w (tbl_idx_w)
   ) i_tbl (
      .op   (ex0_op),
      .idx  (frac_d[gst_frac_w-1 -: tbl_idx_w]),
      .corr (corr_d)
   );

   // ------------------------------
   // ex1 registers
   // ------------------------------
   always_ff @(posedge nclk) begin
      if (rst) begin
         ex1.valid <= 1'b0;
      end else begin
         ex1.valid <= ex0_valid;
      end
   end

   always_ff @(posedge nclk) begin
      ex1.op       <= ex0_op;
      ex1.int_part <= int_d;
      ex1.frac     <= frac_d;
      ex1.corr     <= corr_d;
      ex1.invalid  <= inv_d;
   end

endmodule : fu_gst_ex1

/* logic/fu_gst_ex1_if.sv */
/*
 * stage 1 to stage 2 bundle of the estimate pipe
 * split operand fields, table correction and invalid flag
 */

`timescale 1ns/1ps

interface fu_gst_ex1_if import fu_gst_pkg::*; ();

   logic                  valid;      // one op per strobe
   gst_op_t               op;
   logic [gst_int_w-1:0]  int_part;   // signed
   logic [gst_frac_w-1:0] frac;
   logic [gst_frac_w-1:0] corr;       // negated for fexpte
   logic                  invalid;

   // stage 1 side
   modport src (output valid, op, int_part, frac, corr, invalid);
   // stage 2 side
   modport dst (input valid, op, int_part, frac, corr, invalid);

endinterface : fu_gst_ex1_if

/* logic/fu_gst_ex2.sv */
/*
 * stage 2 of the estimate pipe
 * fraction correction through the prefix adder
 * result packing per opcode, output registers
 */

`timescale 1ns/1ps

module fu_gst_ex2 import fu_gst_pkg::*; (
   input  logic         nclk,
   input  logic         rst,
   fu_gst_ex1_if.dst    ex1,
   output logic         ex2_valid,
   output logic [31:0]  ex2_rslt,
   output logic         ex2_invalid
);

   logic [gst_frac_w-1:0] sum;       // corrected fraction
   logic [gst_int_w-1:0]  exp_d;     // biased exponent for fexpte
   logic [31:0]           rslt_d;

   // adder takes both addends inverted
   fu_gst_add11 i_add (
      .a_b (~ex1.frac),
      .b_b (~ex1.corr),
      .s0  (sum)
   );

   assign exp_d = ex1.int_part + gst_int_w'(gst_exp_bias);

   // ------------------------------
   // result pack
   // ------------------------------
   always_comb begin
      if (ex1.invalid) begin
         rslt_d = '0;                        // flagged ops return zero
      end else if (ex1.op == op_floge) begin
         // 8.11 fixed point, sign extended
         rslt_d = {{(32 - gst_fix_w){ex1.int_part[gst_int_w-1]}},
                   ex1.int_part, sum};
      end else begin
         // positive float, low mantissa bits zero
         rslt_d = {1'b0, exp_d, sum, {(23 - gst_frac_w){1'b0}}};
      end
   end

   // ------------------------------
   // ex2 registers
   // ------------------------------
   always_ff @(posedge nclk) begin
      if (rst) begin
         ex2_valid <= 1'b0;
      end else begin
         ex2_valid <= ex1.valid;
      end
   end

   always_ff @(posedge nclk) begin
      ex2_rslt    <= rslt_d;
      ex2_invalid <= ex1.invalid;
   end

endmodule : fu_gst_ex2

/* logic/fu_gst_pkg.sv */
/*
 * shared definitions for the graphics estimate side pipe
 *   opcode enum for floge and fexpte
 *   widths of the 8.11 fixed point estimate format
 *   single precision exponent bias and fexpte range limits
 */

package fu_gst_pkg;

   // estimate opcodes
   typedef enum logic {
      op_floge  = 1'b0,   // log2 estimate, float in, fixed out
      op_fexpte = 1'b1    // 2**x estimate, fixed in, float out
   } gst_op_t;

   // ------------------------------
   // fixed point format
   // ------------------------------
   localparam int gst_frac_w = 11;                      // fraction bits
   localparam int gst_int_w  = 8;                       // signed integer bits
   localparam int gst_fix_w  = gst_int_w + gst_frac_w;  // 19 total

   // ------------------------------
   // single precision
   // ------------------------------
   localparam int gst_exp_bias = 127;

   // integer parts that still give a normal result on fexpte
   localparam int gst_exp_min = -126;   // biased exponent 1
   localparam int gst_exp_max = 127;    // biased exponent 254

endpackage : fu_gst_pkg

/* logic/fu_gst_tbl.sv */
/*
 * piecewise linear correction tables
 *   log table adds mean of log2(1+f) - f per segment
 *   exp table holds minus mean of f - (2**f - 1) per segment
 */

`timescale 1ns/1ps

module fu_gst_tbl import fu_gst_pkg::*; #(
   parameter int tbl_idx_w = 4
) (
   input  gst_op_t                op,
   input  logic [tbl_idx_w-1:0]   idx,    // top fraction bits
   output logic [gst_frac_w-1:0]  corr
);

   localparam int n_ent = 1 << tbl_idx_w;

   // ------------------------------
   // floge entries, scaled by 2048
   // ------------------------------
   // last segment forced to 0 so frac + corr stays below 2048
   localparam logic [gst_frac_w-1:0] log_tbl [n_ent] = '{
      11'd26,  11'd72,  11'd109, 11'd136,
      11'd156, 11'd169, 11'd175, 11'd176,
      11'd171, 11'd161, 11'd147, 11'd128,
      11'd106, 11'd80,  11'd50,  11'd0
   };

   // ------------------------------
   // fexpte entries, two's complement
   // ------------------------------
   // 2048 - mean, the adder has no carry in to do the subtract
   localparam logic [gst_frac_w-1:0] exp_tbl [n_ent] = '{
      11'd2029, 11'd1994, 11'd1962, 11'd1935,
      11'd1913, 11'd1895, 11'd1882, 11'd1874,
      11'd1872, 11'd1875, 11'd1884, 11'd1899,
      11'd1920, 11'd1948, 11'd1983, 11'd2025
   };

   always_comb begin
      if (op == op_floge) begin
         corr = log_tbl[idx];
      end else begin
         corr = exp_tbl[idx];
      end
   end

endmodule : fu_gst_tbl

/* verification/fu_gst_testdata.txt */
# op (0 floge, 1 fexpte, 2 idle), operand hex, expected result hex, expected invalid
# floge gives 8.11 fixed point sign extended, fexpte gives a single precision float
2 00000000 00000000 0
0 3f800000 0000001a 0
0 40000000 0000081a 0
0 3f000000 fffff81a 0
0 40400000 00000cab 0
0 3fc00000 000004ab 0
0 41200000 00001a9c 0
0 3f400000 fffffcab 0
0 3ff80000 00000780 0
0 3f8fffff 00000147 0
0 7f000000 0003f81a 0
0 00800000 fffc101a 0
0 40c90fdb 00001531 0
0 bf800000 00000000 1
0 00000000 00000000 1
0 7f800000 00000000 1
0 7fc00000 00000000 1
0 00400000 00000000 1
2 00000000 00000000 0
1 00000000 3ffed000 0
1 00000800 407ed000 0
1 00000400 3fb50000 0
1 00001600 40d80000 0
1 fffff800 3f7ed000 0
1 fffffc00 3f350000 0
1 fffc1000 00fed000 0
1 0003ffff 7f7e8000 0
1 0000192c 410d6000 0
1 ffffe8c8 3e092000 0
1 00040000 00000000 1
1 fffc0800 00000000 1
0 40400000 00000cab 0
2 00000000 00000000 0
1 00000400 3fb50000 0
2 00000000 00000000 0
2 00000000 00000000 0
0 bf800000 00000000 1
1 00100000 00000000 1
0 3f800000 0000001a 0

/* verification/tb_clkgen.sv */
/*
 * free running clock for the estimate pipe testbench
 * starts low, first rising edge after half a period
 */

`timescale 1ns/1ps

module tb_clkgen #(
   parameter int period = 40   // ns
) (
   output logic nclk
);

   initial begin
      nclk = 1'b0;
      forever #(period / 2) nclk = ~nclk;   // 50 percent duty
   end

endmodule : tb_clkgen

/* verification/tb_fu_gst.sv */
/*
 * testbench for the graphics estimate side pipe
 *   vector file reader and one op per cycle driver
 *   in order monitor with fixed latency check
 *   watchdog sized from the vector count
 */

`timescale 1ns/1ps

module tb_fu_gst import fu_gst_pkg::*; ();

   localparam int clk_period = 40;   // ns
   localparam int drive_dly  = 1;    // ns after rising edge
   localparam int rst_cycles = 8;
   localparam int latency    = 2;    // drive edge to result edge
   localparam int wd_slack   = 20;   // cycles on top of the vectors

   logic        nclk;
   logic        rst;
   logic        ex0_valid;
   gst_op_t     ex0_op;
   logic [31:0] ex0_opnd;
   logic        ex2_valid;
   logic [31:0] ex2_rslt;
   logic        ex2_invalid;

   // vectors as read including idle slots
   int          vec_op[$];     // 0 floge, 1 fexpte, 2 idle
   logic [31:0] vec_opnd[$];
   logic [31:0] vec_rslt[$];
   logic        vec_inv[$];

   // ops in flight with the oldest first
   logic [31:0] exp_rslt_q[$];
   logic        exp_inv_q[$];
   int          exp_due_q[$];  // cycle the result is due

   int          cyc;           // rising edges so far
   bit          loaded;
   logic [31:0] exp_rslt;
   logic        exp_inv;
   int          exp_due;

   tb_clkgen #(
      .period (clk_period)
   ) i_clkgen (
      .nclk (nclk)
   );

   fu_gst #(
      .tbl_idx_w (4)
   ) i_fu_gst (
      .nclk        (nclk),
      .rst         (rst),
      .ex0_valid   (ex0_valid),
      .ex0_op      (ex0_op),
      .ex0_opnd    (ex0_opnd),
      .ex2_valid   (ex2_valid),
      .ex2_rslt    (ex2_rslt),
      .ex2_invalid (ex2_invalid)
   );

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("*** FAILED ***");
      $fatal(1, "run stopped at the first error");
   endtask

   // one vector per line and # lines skipped
   task automatic read_vectors();
      int          fd;
      int          n;
      string       line;
      int          op;
      logic [31:0] opnd;
      logic [31:0] rslt;
      int          inv;
      fd = $fopen("verification/fu_gst_testdata.txt", "r");
      assert (fd != 0) else stop_on_error("cannot open the vector file");
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 0 && line[0] != "#") begin
            n = $sscanf(line, "%d %h %h %d", op, opnd, rslt, inv);
            if (n == 4) begin
               vec_op.push_back(op);
               vec_opnd.push_back(opnd);
               vec_rslt.push_back(rslt);
               vec_inv.push_back(inv[0]);
            end
         end
      end
      $fclose(fd);
   endtask

   always @(posedge nclk) cyc <= cyc + 1;

   // ------------------------------
   // stimulus
   // ------------------------------
   initial begin
      $timeformat(-9, 0, " ns", 0);
      rst        = 1'b1;
      ex0_valid  = 1'b0;
      ex0_op     = op_floge;
      ex0_opnd   = '0;
      cyc        = 0;
      loaded     = 1'b0;
      read_vectors();
      loaded = 1'b1;                      // arms the watchdog
      repeat (rst_cycles) @(posedge nclk);
      #drive_dly;
      rst = 1'b0;
      foreach (vec_op[i]) begin
         ex0_valid = (vec_op[i] != 2);    // idle slot drives valid low
         ex0_op    = gst_op_t'(vec_op[i] == 1);
         ex0_opnd  = vec_opnd[i];
         if (vec_op[i] != 2) begin
            exp_rslt_q.push_back(vec_rslt[i]);
            exp_inv_q.push_back(vec_inv[i]);
            exp_due_q.push_back(cyc + latency);
         end
         @(posedge nclk);
         #drive_dly;
      end
      ex0_valid = 1'b0;
      while (exp_rslt_q.size() != 0) @(posedge nclk);
      repeat (3) @(posedge nclk);         // quiet tail to catch a stray valid
      @(negedge nclk);
      #drive_dly;                         // after the last monitor look
      $display("*** PASSED ***");
      $finish;
   end

   // ------------------------------
   // monitor sampling mid cycle
   // ------------------------------
   always @(negedge nclk) begin
      if (cyc > 0) begin                  // registers unknown before the first edge
         if (rst) begin
            assert (ex2_valid === 1'b0)
               else stop_on_error($sformatf(
                  "mismatch at %0t: ex2_valid expected 0 actual %b",
                  $time, ex2_valid));
         end else begin
            assert (!$isunknown(ex2_valid))
               else stop_on_error("ex2_valid is unknown after reset");
            if (ex2_valid === 1'b1) begin
               assert (exp_rslt_q.size() > 0)
                  else stop_on_error("ex2_valid went high with no operation in flight");
               exp_rslt = exp_rslt_q.pop_front();
               exp_inv  = exp_inv_q.pop_front();
               exp_due  = exp_due_q.pop_front();
               assert (cyc == exp_due)
                  else stop_on_error($sformatf(
                     "mismatch at %0t: ex2_valid cycle expected %0d actual %0d",
                     $time, exp_due, cyc));
               assert (ex2_invalid === exp_inv)
                  else stop_on_error($sformatf(
                     "mismatch at %0t: ex2_invalid expected %b actual %b",
                     $time, exp_inv, ex2_invalid));
               assert (ex2_rslt === exp_rslt)
                  else stop_on_error($sformatf(
                     "mismatch at %0t: ex2_rslt expected %08h actual %08h",
                     $time, exp_rslt, ex2_rslt));
            end
         end
      end
   end

   // ------------------------------
   // watchdog
   // ------------------------------
   initial begin
      wait (loaded);
      #((vec_op.size() + wd_slack) * clk_period);
      stop_on_error("watchdog expired, the pipe stopped producing results");
   end

endmodule : tb_fu_gst
